// ==== hw/u712_defines.svh ====
`ifndef U712_DEFINES_SVH
`define U712_DEFINES_SVH

// CPU address bits seen by the bridge, A[20:0]
`define ADDR_W 21

// Multiplexed chip memory address width
`define CMA_W 11

// Data strobe window of a register cycle, in CLK80 cycles
`define REG_STROBE_CYCLES 6

// Chip RAM strobe timing, in CLK80 cycles
`define RAS_TO_CAS 2
`define CAS_CYCLES 3

// Idle time after RAS and CAS return high
`define PRECHARGE 2

`endif

// ==== hw/u712Pkg.sv ====
`default_nettype none
`include "u712_defines.svh"

package u712Pkg;

    // Address space of the current CPU transfer
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REGCYC   = 2'd1,
        RAMCYC   = 2'd2,
        UNMAPPED = 2'd3
    } cycleKind_t;

    // 68040 SIZ pins, lines run as longwords
    typedef enum logic [1:0] {
        LONG = 2'b00,
        BYTE = 2'b01,
        WORD = 2'b10,
        LINE = 2'b11
    } xferSize_t;

    // Chipset register cycle
    typedef enum logic [2:0] {
        REG_IDLE,
        REG_PHASEWAIT,
        REG_ADDR,
        REG_STROBE,
        REG_DONE
    } regState_t;

    // Chip RAM cycle
    typedef enum logic [2:0] {
        RAM_IDLE,
        RAM_BUSWAIT,
        RAM_ROW,
        RAM_COL,
        RAM_PRECHG
    } ramState_t;

    // Transfer record captured at TSn
    typedef struct packed {
        cycleKind_t         kind;
        logic               write;
        xferSize_t          size;
        logic [`ADDR_W-1:0] addr;
        logic [3:0]         lanes;  // Bit 0 is UUBE
    } cpuReq_t;

    // End-of-cycle pulses from both machines
    typedef struct packed {
        logic regDone;
        logic ramDone;
    } cycleDone_t;

endpackage

`default_nettype wire

// ==== hw/cpuBusFront.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "u712_defines.svh"

module cpuBusFront
    import u712Pkg::*;
(
    input  logic               CLK80,
    input  logic               RESETn,
    input  logic               TSn,
    input  logic               RnW,
    input  logic               REGSPACEn,
    input  logic               RAMSPACEn,
    input  logic               DBRn,
    input  logic [1:0]         SIZ,
    input  logic [`ADDR_W-1:0] A,
    output cpuReq_t            req,
    output logic               reqStart,
    output logic               dbrSync
);

    logic [1:0] dbrPipe;
    logic [3:0] laneMask;
    cycleKind_t kindNext;

    //////////////////////////////////////////////////////////////////////
    // Transfer decode
    //////////////////////////////////////////////////////////////////////

    // Lane 0 is the most significant byte
    always_comb begin
        unique case (xferSize_t'(SIZ))
            BYTE:    laneMask = 4'b0001 << A[1:0];
            // Upper or lower word by A1
            WORD:    laneMask = A[1] ? 4'b1100 : 4'b0011;
            // Long and line both take all lanes
            default: laneMask = 4'b1111;
        endcase
    end

    // Register space wins if both selects are low
    always_comb begin
        if (!REGSPACEn) begin
            kindNext = REGCYC;
        end else if (!RAMSPACEn) begin
            kindNext = RAMCYC;
        end else begin
            kindNext = UNMAPPED;
        end
    end

    // Start pulse, one cycle after TSn is seen
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            reqStart <= 1'b0;
        end else begin
            reqStart <= !TSn;
        end
    end

    // Attributes held until the next start
    always_ff @(posedge CLK80) begin
        if (!TSn) begin
            req.kind  <= kindNext;
            req.write <= !RnW;
            req.size  <= xferSize_t'(SIZ);
            req.addr  <= A;
            req.lanes <= laneMask;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // DBRn synchronizer
    //////////////////////////////////////////////////////////////////////

    // Shared by every consumer of the bus request
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            dbrPipe <= 2'b11;
        end else begin
            dbrPipe <= {dbrPipe[0], DBRn};
        end
    end

    assign dbrSync = dbrPipe[1];

endmodule

`default_nettype wire

// ==== hw/regCycleSm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "u712_defines.svh"

module regCycleSm
    import u712Pkg::*;
(
    input  logic    CLK80,
    input  logic    RESETn,
    input  logic    C1,
    input  logic    C3,
    input  cpuReq_t req,
    input  logic    reqStart,
    output logic    ASn,
    output logic    REGENn,
    output logic    dsEnable,
    output logic    regDone
);

    localparam int STB_W = $clog2(`REG_STROBE_CYCLES + 1);

    regState_t        state;
    logic [STB_W-1:0] stbCnt;

    //////////////////////////////////////////////////////////////////////
    // 68000-style register cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state    <= REG_IDLE;
            ASn      <= 1'b1;
            REGENn   <= 1'b1;
            dsEnable <= 1'b0;
            regDone  <= 1'b0;
            stbCnt   <= '0;
        end else begin
            // Done is a single-cycle pulse
            regDone <= 1'b0;
            unique case (state)
                REG_IDLE: begin
                    if (reqStart && req.kind == REGCYC) begin
                        state <= REG_PHASEWAIT;
                    end
                end
                // Line up with the chipset phase, C1 high and C3 low
                REG_PHASEWAIT: begin
                    if (C1 && !C3) begin
                        state  <= REG_ADDR;
                        ASn    <= 1'b0;
                        REGENn <= 1'b0;
                    end
                end
                // Address setup before the data strobes
                REG_ADDR: begin
                    state    <= REG_STROBE;
                    dsEnable <= 1'b1;
                    stbCnt   <= '0;
                end
                REG_STROBE: begin
                    if (stbCnt == STB_W'(`REG_STROBE_CYCLES - 1)) begin
                        // All strobes release on the same edge
                        state    <= REG_DONE;
                        ASn      <= 1'b1;
                        REGENn   <= 1'b1;
                        dsEnable <= 1'b0;
                        regDone  <= 1'b1;
                    end else begin
                        stbCnt <= stbCnt + 1'b1;
                    end
                end
                // Recovery cycle while done is out
                REG_DONE: begin
                    state <= REG_IDLE;
                end
                default: begin
                    state <= REG_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/chipRamSm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "u712_defines.svh"

module chipRamSm
    import u712Pkg::*;
(
    input  logic              CLK80,
    input  logic              RESETn,
    input  cpuReq_t           req,
    input  logic              reqStart,
    input  logic              dbrSync,
    output logic              RASn,
    output logic              CASn,
    output logic              WEn,
    output logic              BANK1,
    output logic              BANK0,
    output logic [`CMA_W-1:0] CMA,
    output logic              ramDone
);

    // One counter covers every delay of the cycle
    localparam int DLY_W = $clog2(`RAS_TO_CAS + `CAS_CYCLES + `PRECHARGE + 1);

    ramState_t        state;
    logic [DLY_W-1:0] dly;
    logic             pending;
    logic             ramStart;

    assign ramStart = reqStart && (req.kind == RAMCYC);

    //////////////////////////////////////////////////////////////////////
    // Chip RAM row/column cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state   <= RAM_IDLE;
            RASn    <= 1'b1;
            CASn    <= 1'b1;
            WEn     <= 1'b1;
            BANK1   <= 1'b0;
            BANK0   <= 1'b0;
            CMA     <= '0;
            ramDone <= 1'b0;
            dly     <= '0;
            pending <= 1'b0;
        end else begin
            ramDone <= 1'b0;
            unique case (state)
                RAM_IDLE: begin
                    if (ramStart) begin
                        state <= RAM_BUSWAIT;
                    end
                end
                // Chipset owns the bus while DBRn is low
                RAM_BUSWAIT: begin
                    if (dbrSync) begin
                        state <= RAM_ROW;
                        RASn  <= 1'b0;
                        CMA   <= req.addr[20:10];
                        BANK1 <= req.addr[9];
                        BANK0 <= req.addr[8];
                        dly   <= '0;
                    end
                end
                RAM_ROW: begin
                    if (dly == DLY_W'(`RAS_TO_CAS - 1)) begin
                        // Column form, A[9:2] with bit 10 set
                        state <= RAM_COL;
                        CASn  <= 1'b0;
                        WEn   <= !req.write;
                        CMA   <= {1'b1, 2'b00, req.addr[9:2]};
                        dly   <= '0;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                RAM_COL: begin
                    if (dly == DLY_W'(`CAS_CYCLES - 1)) begin
                        state   <= RAM_PRECHG;
                        RASn    <= 1'b1;
                        CASn    <= 1'b1;
                        WEn     <= 1'b1;
                        ramDone <= 1'b1;
                        dly     <= '0;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                // Keep a start that lands during precharge
                RAM_PRECHG: begin
                    if (ramStart) begin
                        pending <= 1'b1;
                    end
                    if (dly == DLY_W'(`PRECHARGE - 1)) begin
                        state   <= (pending || ramStart) ? RAM_BUSWAIT : RAM_IDLE;
                        pending <= 1'b0;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                default: begin
                    state <= RAM_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/busResponse.sv ====
`timescale 1ns/1ps
`default_nettype none

module busResponse
    import u712Pkg::*;
(
    input  logic       CLK80,
    input  logic       RESETn,
    input  cpuReq_t    req,
    input  logic       reqStart,
    input  logic       dsEnable,
    input  cycleDone_t done,
    output logic       UUBEn,
    output logic       UMBEn,
    output logic       LMBEn,
    output logic       LLBEn,
    output logic       UDSn,
    output logic       LDSn,
    output logic       TACKn
);

    logic       cycleOpen;
    logic       cycleMapped;
    logic [3:0] laneHold;
    logic       unmapDone;
    logic       anyDone;
    logic [3:0] laneActive;

    //////////////////////////////////////////////////////////////////////
    // Byte enables and data strobes
    //////////////////////////////////////////////////////////////////////

    // Lanes only while a mapped cycle is open
    assign laneActive = laneHold & {4{cycleOpen && cycleMapped}};

    assign UUBEn = !laneActive[0];
    assign UMBEn = !laneActive[1];
    assign LMBEn = !laneActive[2];
    assign LLBEn = !laneActive[3];

    // Upper strobe on even lanes, lower on odd
    assign UDSn = !(dsEnable && (laneHold[0] || laneHold[2]));
    assign LDSn = !(dsEnable && (laneHold[1] || laneHold[3]));

    //////////////////////////////////////////////////////////////////////
    // Termination
    //////////////////////////////////////////////////////////////////////

    assign anyDone = done.regDone || done.ramDone || unmapDone;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            cycleOpen <= 1'b0;
            unmapDone <= 1'b0;
            TACKn     <= 1'b1;
        end else begin
            // Unmapped space ends on its own
            unmapDone <= reqStart && (req.kind == UNMAPPED);
            TACKn     <= !anyDone;
            if (reqStart) begin
                cycleOpen <= 1'b1;
            end else if (anyDone) begin
                cycleOpen <= 1'b0;
            end
        end
    end

    // Lanes captured once per transfer
    always_ff @(posedge CLK80) begin
        if (reqStart) begin
            laneHold    <= req.lanes;
            cycleMapped <= (req.kind == REGCYC) || (req.kind == RAMCYC);
        end
    end

endmodule

`default_nettype wire

// ==== hw/u712Top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "u712_defines.svh"

module u712Top
    import u712Pkg::*;
(
    input  logic               CLK80,
    input  logic               RESETn,
    input  logic               C1,
    input  logic               C3,
    input  logic               TSn,
    input  logic               RnW,
    input  logic               REGSPACEn,
    input  logic               RAMSPACEn,
    input  logic               DBRn,
    input  logic [1:0]         SIZ,
    input  logic [`ADDR_W-1:0] A,
    output logic               ASn,
    output logic               REGENn,
    output logic               UDSn,
    output logic               LDSn,
    output logic               RASn,
    output logic               CASn,
    output logic               WEn,
    output logic               BANK1,
    output logic               BANK0,
    output logic [`CMA_W-1:0]  CMA,
    output logic               UUBEn,
    output logic               UMBEn,
    output logic               LMBEn,
    output logic               LLBEn,
    output logic               TACKn
);

    cpuReq_t         req;
    logic            reqStart;
    logic            dbrSync;
    logic            dsEnable;
    wire cycleDone_t done;

    //////////////////////////////////////////////////////////////////////
    // CPU side decode
    //////////////////////////////////////////////////////////////////////

    cpuBusFront cpuBusFront (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .TSn       (TSn),
        .RnW       (RnW),
        .REGSPACEn (REGSPACEn),
        .RAMSPACEn (RAMSPACEn),
        .DBRn      (DBRn),
        .SIZ       (SIZ),
        .A         (A),
        .req       (req),
        .reqStart  (reqStart),
        .dbrSync   (dbrSync)
    );

    //////////////////////////////////////////////////////////////////////
    // Cycle engines
    //////////////////////////////////////////////////////////////////////

    regCycleSm regCycleSm (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .C1       (C1),
        .C3       (C3),
        .req      (req),
        .reqStart (reqStart),
        .ASn      (ASn),
        .REGENn   (REGENn),
        .dsEnable (dsEnable),
        .regDone  (done.regDone)
    );

    chipRamSm chipRamSm (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .req      (req),
        .reqStart (reqStart),
        .dbrSync  (dbrSync),
        .RASn     (RASn),
        .CASn     (CASn),
        .WEn      (WEn),
        .BANK1    (BANK1),
        .BANK0    (BANK0),
        .CMA      (CMA),
        .ramDone  (done.ramDone)
    );

    //////////////////////////////////////////////////////////////////////
    // Lanes, strobes and TACKn
    //////////////////////////////////////////////////////////////////////

    busResponse busResponse (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .req      (req),
        .reqStart (reqStart),
        .dsEnable (dsEnable),
        .done     (done),
        .UUBEn    (UUBEn),
        .UMBEn    (UMBEn),
        .LMBEn    (LMBEn),
        .LLBEn    (LLBEn),
        .UDSn     (UDSn),
        .LDSn     (LDSn),
        .TACKn    (TACKn)
    );

endmodule

`default_nettype wire

// ==== bench/u712_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridgeAsserts (
    input logic CLK80,
    input logic RESETn,
    input logic ASn,
    input logic RASn,
    input logic CASn,
    input logic TACKn
);

    //////////////////////////////////////////////////////////////////////
    // Bus protocol rules
    //////////////////////////////////////////////////////////////////////

    // Termination is a single-cycle pulse
    tackSingle: assert property (@(posedge CLK80) disable iff (!RESETn)
        !TACKn |=> TACKn)
        else $error("TACKn held low for more than one cycle");

    // Register and chip RAM cycles never overlap
    noOverlap: assert property (@(posedge CLK80) disable iff (!RESETn)
        !ASn |-> (RASn && CASn))
        else $error("RASn or CASn low during a register cycle");

    // No CAS before RAS
    casAfterRas: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(CASn) |-> !RASn)
        else $error("CASn fell while RASn was high");

endmodule

bind u712Top bridgeAsserts asserts (
    .CLK80  (CLK80),
    .RESETn (RESETn),
    .ASn    (ASn),
    .RASn   (RASn),
    .CASn   (CASn),
    .TACKn  (TACKn)
);

`default_nettype wire

// ==== bench/u712Tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "u712_defines.svh"

module u712Tb;

    // 68040 SIZ codes
    // Long and line take the default branch
    localparam logic [1:0] SIZ_BYTE = 2'b01;
    localparam logic [1:0] SIZ_WORD = 2'b10;

    localparam int KIND_REG  = 0;
    localparam int KIND_RAM  = 1;
    localparam int KIND_NONE = 2;
    localparam int AW        = `ADDR_W;

    // Per-transfer limit and overall watchdog budget
    localparam int XFER_LIMIT   = 40;
    localparam int NUM_XFERS    = 48;
    localparam int WORST_CYCLES = 64;
    localparam int WATCHDOG_NS  = (NUM_XFERS * WORST_CYCLES + 100) * 10;

    logic CLK80, RESETn, C1, C3, TSn, RnW, REGSPACEn, RAMSPACEn, DBRn;
    logic [1:0] SIZ;
    logic [`ADDR_W-1:0] A;
    logic ASn, REGENn, UDSn, LDSn, RASn, CASn, WEn, BANK1, BANK0;
    logic UUBEn, UMBEn, LMBEn, LLBEn, TACKn;
    logic [`CMA_W-1:0] CMA;
    logic [2:0] phase;
    int unsigned seedVal;

    // What one transfer showed on the outputs
    int tackLow, asLow, udsLow, ldsLow, rasOnly, casLow, doneCycle;
    logic [3:0] lanesSeen;
    logic [`CMA_W-1:0] rowCma, colCma;
    logic [1:0] bankSeen;
    logic weSeen, phaseOk, regenSplit;

    u712Top DUT (
        .CLK80(CLK80), .RESETn(RESETn), .C1(C1), .C3(C3), .TSn(TSn), .RnW(RnW),
        .REGSPACEn(REGSPACEn), .RAMSPACEn(RAMSPACEn), .DBRn(DBRn), .SIZ(SIZ), .A(A),
        .ASn(ASn), .REGENn(REGENn), .UDSn(UDSn), .LDSn(LDSn), .RASn(RASn),
        .CASn(CASn), .WEn(WEn), .BANK1(BANK1), .BANK0(BANK0), .CMA(CMA),
        .UUBEn(UUBEn), .UMBEn(UMBEn), .LMBEn(LMBEn), .LLBEn(LLBEn), .TACKn(TACKn)
    );

    initial begin
        CLK80 = 1'b0;
        forever #5 CLK80 = ~CLK80;
    end

    // Chipset phase pair over 8 clocks
    // C3 leads C1 by a quarter period
    initial begin
        phase = 3'd0;
        forever begin
            @(negedge CLK80);
            phase <= phase + 3'd1;
        end
    end

    assign C1 = phase[2];
    assign C3 = phase[2] ^ phase[1];

    initial begin
        #(WATCHDOG_NS);
        abortRun("watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic abortRun(input string why);
        $display("error: %s", why);
        stopRun();
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s (%s): expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            stopRun();
        end
    endtask

    // Lane mask by SIZ and A[1:0]
    // Lane 0 is UUBE
    function automatic logic [3:0] laneRule(input logic [1:0] siz, input logic [1:0] a);
        logic [3:0] m;
        m = 4'b0000;
        case (siz)
            SIZ_BYTE: m[a] = 1'b1;
            SIZ_WORD: begin
                m[{a[1], 1'b0}] = 1'b1;
                m[{a[1], 1'b1}] = 1'b1;
            end
            default: m = 4'b1111;
        endcase
        return m;
    endfunction

    // Outputs settled since the last posedge
    // C1/C3 still show the values of that edge
    task automatic sampleOutputs();
        if (!TACKn) begin
            tackLow++;
        end
        if (!ASn) begin
            if (asLow == 0) begin
                phaseOk = C1 && !C3;
            end
            asLow++;
        end
        if (ASn !== REGENn) begin
            regenSplit = 1'b1;
        end
        if (!UDSn) begin
            udsLow++;
        end
        if (!LDSn) begin
            ldsLow++;
        end
        lanesSeen |= {!LLBEn, !LMBEn, !UMBEn, !UUBEn};
        if (!RASn && CASn) begin
            rasOnly++;
            rowCma   = CMA;
            bankSeen = {BANK1, BANK0};
        end
        if (!CASn) begin
            casLow++;
            colCma = CMA;
            weSeen = WEn;
        end
        if (!DBRn && !RASn) begin
            abortRun("RASn fell while DBRn was still held low");
        end
    endtask

    // One CPU transfer from the TSn pulse to TACKn
    task automatic runTransfer(input string testName, input int kind, input logic write,
                               input logic [1:0] siz, input logic [`ADDR_W-1:0] addr,
                               input int dbrHold);
        int cyc;
        bit ended;
        tackLow = 0;
        asLow = 0;
        udsLow = 0;
        ldsLow = 0;
        rasOnly = 0;
        casLow = 0;
        lanesSeen = 4'b0000;
        phaseOk = 1'b0;
        regenSplit = 1'b0;
        @(negedge CLK80);
        TSn       = 1'b0;
        REGSPACEn = (kind != KIND_REG);
        RAMSPACEn = (kind != KIND_RAM);
        RnW       = !write;
        SIZ       = siz;
        A         = addr;
        @(negedge CLK80);
        TSn   = 1'b1;
        cyc   = 0;
        ended = 1'b0;
        while (!ended) begin
            sampleOutputs();
            if (!TACKn) begin
                ended     = 1'b1;
                doneCycle = cyc;
            end else if (cyc >= XFER_LIMIT + dbrHold) begin
                abortRun($sformatf("no TACKn termination arrived in test %s", testName));
            end else begin
                // Chipset gives the bus back
                if (cyc == dbrHold) begin
                    DBRn = 1'b1;
                end
                @(negedge CLK80);
                cyc++;
            end
        end
        @(negedge CLK80);
        sampleOutputs();
        checkValue(testName, "TACKn pulses", 1, tackLow);
        repeat (3) @(negedge CLK80);
    endtask

    task automatic checkRegResult(input string testName, input logic [3:0] lanes);
        checkValue(testName, "C1/C3 phase at ASn", 1, 32'(phaseOk));
        checkValue(testName, "REGENn follows ASn", 0, 32'(regenSplit));
        checkValue(testName, "ASn cycles", `REG_STROBE_CYCLES + 1, asLow);
        checkValue(testName, "UDSn cycles", (lanes[0] || lanes[2]) ? `REG_STROBE_CYCLES : 0,
                   udsLow);
        checkValue(testName, "LDSn cycles", (lanes[1] || lanes[3]) ? `REG_STROBE_CYCLES : 0,
                   ldsLow);
        checkValue(testName, "lanes", 32'(lanes), 32'(lanesSeen));
        checkValue(testName, "RAM strobes", 0, rasOnly + casLow);
    endtask

    task automatic checkRamResult(input string testName, input logic write,
                                  input logic [`ADDR_W-1:0] addr, input logic [3:0] lanes);
        checkValue(testName, "row CMA", 32'(addr[20:10]), 32'(rowCma));
        checkValue(testName, "BANK", 32'(addr[9:8]), 32'(bankSeen));
        checkValue(testName, "RAS to CAS", `RAS_TO_CAS, rasOnly);
        checkValue(testName, "CAS cycles", `CAS_CYCLES, casLow);
        checkValue(testName, "column CMA", 32'(addr[9:2]) | 32'h400, 32'(colCma));
        checkValue(testName, "WEn", 32'(!write), 32'(weSeen));
        checkValue(testName, "ASn cycles", 0, asLow);
        checkValue(testName, "lanes", 32'(lanes), 32'(lanesSeen));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic testReset();
        checkValue("reset", "strobes", 32'hFFF, 32'({ASn, REGENn, UDSn, LDSn, RASn, CASn,
                   WEn, UUBEn, UMBEn, LMBEn, LLBEn, TACKn}));
        checkValue("reset", "CMA", 0, 32'(CMA));
        checkValue("reset", "BANK", 0, 32'({BANK1, BANK0}));
    endtask

    // Reads then writes
    task automatic testRegCycles();
        logic [`ADDR_W-1:0] addr;
        logic [1:0] siz;
        for (int i = 0; i < 4; i++) begin
            addr = AW'($urandom());
            siz  = 2'($urandom());
            runTransfer("regCycles", KIND_REG, i >= 2, siz, addr, 0);
            checkRegResult("regCycles", laneRule(siz, addr[1:0]));
        end
    endtask

    task automatic testRamCycles();
        logic [`ADDR_W-1:0] addr;
        logic [1:0] siz;
        logic write;
        for (int i = 0; i < 8; i++) begin
            addr  = AW'($urandom());
            siz   = 2'($urandom());
            write = 1'($urandom());
            runTransfer("ramCycles", KIND_RAM, write, siz, addr, 0);
            checkRamResult("ramCycles", write, addr, laneRule(siz, addr[1:0]));
        end
    endtask

    // Every SIZ and A[1:0] pair in both spaces
    task automatic testByteLanes();
        logic [`ADDR_W-1:0] addr;
        for (int s = 0; s < 4; s++) begin
            for (int a = 0; a < 4; a++) begin
                addr = {(AW-2)'($urandom()), 2'(a)};
                runTransfer("byteLanes", KIND_REG, 1'b0, 2'(s), addr, 0);
                checkRegResult("byteLanes", laneRule(2'(s), 2'(a)));
                runTransfer("byteLanes", KIND_RAM, 1'b1, 2'(s), addr, 0);
                checkRamResult("byteLanes", 1'b1, addr, laneRule(2'(s), 2'(a)));
            end
        end
    endtask

    task automatic testDbrHold();
        logic [`ADDR_W-1:0] addr;
        int hold;
        for (int i = 0; i < 2; i++) begin
            hold = 12 + 8 * i;
            addr = AW'($urandom());
            DBRn = 1'b0;
            repeat (2) @(negedge CLK80);
            runTransfer("dbrHold", KIND_RAM, 1'b0, SIZ_WORD, addr, hold);
            checkRamResult("dbrHold", 1'b0, addr, laneRule(SIZ_WORD, addr[1:0]));
        end
    endtask

    // Ends two cycles after the start pulse
    task automatic testUnmapped();
        for (int i = 0; i < 2; i++) begin
            runTransfer("unmapped", KIND_NONE, i == 1, SIZ_BYTE, AW'($urandom()), 0);
            checkValue("unmapped", "TACKn latency", 2, doneCycle);
            checkValue("unmapped", "ASn cycles", 0, asLow);
            checkValue("unmapped", "RAM strobes", 0, rasOnly + casLow);
            checkValue("unmapped", "lanes", 0, 32'(lanesSeen));
        end
    endtask

    initial begin
        seedVal   = $urandom(32'h5ac0);
        RESETn    = 1'b0;
        TSn       = 1'b1;
        RnW       = 1'b1;
        REGSPACEn = 1'b1;
        RAMSPACEn = 1'b1;
        DBRn      = 1'b1;
        SIZ       = 2'b00;
        A         = '0;
        repeat (3) @(negedge CLK80);
        RESETn = 1'b1;
        @(negedge CLK80);
        testReset();
        testRegCycles();
        testRamCycles();
        testByteLanes();
        testDbrHold();
        testUnmapped();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/u712Pkg.sv
hw/cpuBusFront.sv
hw/regCycleSm.sv
hw/chipRamSm.sv
hw/busResponse.sv
hw/u712Top.sv
bench/u712_asserts.sv
bench/u712Tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module u712Tb -f compile.f -o u712Sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/u712Sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
